// File: common/mem_pkg.sv
package mem_pkg;

  // bus widths
  localparam int ADDR_W = 64;
  localparam int DATA_W = 64;

  // memory transaction tag, zero means no tag
  localparam int TAG_W    = 4;
  localparam int NUM_TAGS = 1 << TAG_W;

  // instruction cache geometry
  localparam int BLOCK_OFS_W    = 3;
  localparam int ICACHE_IDX_W   = 5;
  localparam int ICACHE_TAG_W   = 8;
  localparam int ICACHE_LINES   = 1 << ICACHE_IDX_W;
  localparam int ICACHE_TAG_LSB = BLOCK_OFS_W + ICACHE_IDX_W;

  // data-side miss queue
  localparam int MSHR_DEPTH = 4;

  typedef logic [ADDR_W-1:0]             addr_t;
  typedef logic [DATA_W-1:0]             data_t;
  typedef logic [TAG_W-1:0]              mem_tag_t;
  typedef logic [ICACHE_IDX_W-1:0]       icache_idx_t;
  typedef logic [ICACHE_TAG_W-1:0]       icache_tag_t;
  typedef logic [$clog2(MSHR_DEPTH)-1:0] mshr_ptr_t;

  // memory bus command
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  // miss queue entry life cycle
  typedef enum logic [1:0] {
    EMPTY      = 2'h0,
    WAIT_ISSUE = 2'h1,
    WAIT_DATA  = 2'h2,
    DONE       = 2'h3
  } mshr_state_e;

endpackage

// File: icache/icache_mem.sv
`timescale 1ns/1ns

module icache_mem (
  input  logic                 clock,
  input  logic                 rst_n,
  input  mem_pkg::icache_idx_t rd_idx,
  input  mem_pkg::icache_tag_t rd_tag,
  input  logic                 wr_en,
  input  mem_pkg::icache_idx_t wr_idx,
  input  mem_pkg::icache_tag_t wr_tag,
  input  mem_pkg::data_t       wr_data,
  output mem_pkg::data_t       rd_data,
  output logic                 rd_valid
);
  import mem_pkg::*;

  logic [ICACHE_LINES-1:0] line_valid;
  icache_tag_t             line_tag  [ICACHE_LINES];
  data_t                   line_data [ICACHE_LINES];

  // valid bits clear on reset and set on fill
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      line_valid <= '0;
    end else if (wr_en) begin
      line_valid[wr_idx] <= 1'b1;
    end
  end

  // tag and data arrays are written on fill
  always_ff @(posedge clock) begin
    if (wr_en) begin
      line_tag[wr_idx]  <= wr_tag;
      line_data[wr_idx] <= wr_data;
    end
  end

  // combinational lookup
  assign rd_data  = line_data[rd_idx];
  assign rd_valid = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);

endmodule

// File: icache/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl (
  input  logic              clock,
  input  logic              rst_n,
  input  mem_pkg::addr_t    fetch_addr,
  input  mem_pkg::mem_tag_t i_response,
  input  mem_pkg::mem_tag_t i_mem_tag,
  input  mem_pkg::data_t    i_mem_data,
  output mem_pkg::data_t    fetch_data,
  output logic              fetch_valid,
  output mem_pkg::bus_cmd_e i_cmd,
  output mem_pkg::addr_t    i_addr
);
  import mem_pkg::*;

  icache_idx_t rd_idx;
  icache_tag_t rd_tag;
  data_t       rd_data;
  logic        rd_valid;

  // fill bookkeeping
  logic        req_active;
  logic        wait_data;
  addr_t       fill_addr;
  mem_tag_t    fill_mem_tag;

  addr_t       block_addr;
  logic        miss_new;
  logic        accepted;
  logic        fill_en;

  // split the fetch address
  assign rd_idx     = fetch_addr[BLOCK_OFS_W +: ICACHE_IDX_W];
  assign rd_tag     = fetch_addr[ICACHE_TAG_LSB +: ICACHE_TAG_W];
  assign block_addr = {fetch_addr[ADDR_W-1:BLOCK_OFS_W], {BLOCK_OFS_W{1'b0}}};

  // only one fill in flight at a time
  // and none starts while reset is held
  assign miss_new = rst_n && !rd_valid && !req_active && !wait_data;

  // a refused request keeps the latched address until memory takes it
  assign i_cmd    = (miss_new || req_active) ? BUS_LOAD : BUS_NONE;
  assign i_addr   = req_active ? fill_addr : block_addr;
  assign accepted = (i_cmd == BUS_LOAD) && (i_response != '0);

  // fill lands on the edge the matching tag shows up
  assign fill_en = wait_data && (i_mem_tag == fill_mem_tag);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      req_active <= 1'b0;
      wait_data  <= 1'b0;
    end else begin
      if (miss_new && !accepted) begin
        req_active <= 1'b1;
      end else if (req_active && accepted) begin
        req_active <= 1'b0;
      end

      if (accepted) begin
        wait_data <= 1'b1;
      end else if (fill_en) begin
        wait_data <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (miss_new) begin
      fill_addr <= block_addr;
    end
    if (accepted) begin
      fill_mem_tag <= i_response;
    end
  end

  icache_mem icache_mem_i (
    .clock    (clock),
    .rst_n    (rst_n),
    .rd_idx   (rd_idx),
    .rd_tag   (rd_tag),
    .wr_en    (fill_en),
    .wr_idx   (fill_addr[BLOCK_OFS_W +: ICACHE_IDX_W]),
    .wr_tag   (fill_addr[ICACHE_TAG_LSB +: ICACHE_TAG_W]),
    .wr_data  (i_mem_data),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  // hit path straight out of the arrays
  assign fetch_data  = rd_data;
  assign fetch_valid = rd_valid;

endmodule

// File: mshr/mshr.sv
`timescale 1ns/1ns

module mshr (
  input  logic              clock,
  input  logic              rst_n,
  input  mem_pkg::bus_cmd_e d_cmd,
  input  mem_pkg::addr_t    d_addr,
  input  mem_pkg::data_t    d_data,
  input  mem_pkg::mem_tag_t m_response,
  input  mem_pkg::mem_tag_t m_mem_tag,
  input  mem_pkg::data_t    m_mem_data,
  output logic              d_ready,
  output logic              d_load_valid,
  output mem_pkg::addr_t    d_load_addr,
  output mem_pkg::data_t    d_load_data,
  output mem_pkg::bus_cmd_e m_cmd,
  output mem_pkg::addr_t    m_addr,
  output mem_pkg::data_t    m_data
);
  import mem_pkg::*;

  mshr_state_e entry_state [MSHR_DEPTH];
  bus_cmd_e    entry_cmd   [MSHR_DEPTH];
  addr_t       entry_addr  [MSHR_DEPTH];
  data_t       entry_data  [MSHR_DEPTH];
  mem_tag_t    entry_tag   [MSHR_DEPTH];

  mshr_ptr_t   tail_ptr;
  mshr_ptr_t   issue_ptr;
  mshr_ptr_t   head_ptr;

  logic                  alloc;
  logic                  issue_ok;
  logic                  retire;
  logic [MSHR_DEPTH-1:0] data_hit;

  // entries are allocated in order, so an empty tail means room
  assign d_ready = (entry_state[tail_ptr] == EMPTY);
  assign alloc   = d_ready && (d_cmd != BUS_NONE);

  // one entry on the bus at a time
  assign m_cmd    = (entry_state[issue_ptr] == WAIT_ISSUE) ? entry_cmd[issue_ptr] : BUS_NONE;
  assign m_addr   = entry_addr[issue_ptr];
  assign m_data   = entry_data[issue_ptr];
  assign issue_ok = (m_cmd != BUS_NONE) && (m_response != '0);

  // match returning data against outstanding loads
  always_comb begin
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      data_hit[i] = (entry_state[i] == WAIT_DATA) && (m_mem_tag != '0) &&
                    (entry_tag[i] == m_mem_tag);
    end
  end

  // head retires as soon as it is done
  assign retire       = (entry_state[head_ptr] == DONE);
  assign d_load_valid = retire && (entry_cmd[head_ptr] == BUS_LOAD);
  assign d_load_addr  = entry_addr[head_ptr];
  assign d_load_data  = entry_data[head_ptr];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tail_ptr  <= '0;
      issue_ptr <= '0;
      head_ptr  <= '0;
      for (int i = 0; i < MSHR_DEPTH; i++) begin
        entry_state[i] <= EMPTY;
      end
    end else begin
      if (alloc) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
      if (issue_ok) begin
        issue_ptr <= issue_ptr + 1'b1;
      end
      if (retire) begin
        head_ptr <= head_ptr + 1'b1;
      end

      // each entry sits in one state, so at most one branch applies
      for (int i = 0; i < MSHR_DEPTH; i++) begin
        if (alloc && (tail_ptr == mshr_ptr_t'(i))) begin
          entry_state[i] <= WAIT_ISSUE;
        end else if (issue_ok && (issue_ptr == mshr_ptr_t'(i))) begin
          // stores are finished once memory takes them
          entry_state[i] <= (entry_cmd[i] == BUS_LOAD) ? WAIT_DATA : DONE;
        end else if (data_hit[i]) begin
          entry_state[i] <= DONE;
        end else if (retire && (head_ptr == mshr_ptr_t'(i))) begin
          entry_state[i] <= EMPTY;
        end
      end
    end
  end

  // entry payload
  always_ff @(posedge clock) begin
    if (alloc) begin
      entry_cmd[tail_ptr]  <= d_cmd;
      entry_addr[tail_ptr] <= d_addr;
      entry_data[tail_ptr] <= d_data;
    end
    if (issue_ok) begin
      entry_tag[issue_ptr] <= m_response;
    end
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      if (data_hit[i]) begin
        entry_data[i] <= m_mem_data;
      end
    end
  end

endmodule

// File: src/mem_bus_arbiter.sv
`timescale 1ns/1ns

module mem_bus_arbiter (
  input  logic              clock,
  input  logic              rst_n,
  input  mem_pkg::bus_cmd_e i_cmd,
  input  mem_pkg::addr_t    i_addr,
  input  mem_pkg::bus_cmd_e m_cmd,
  input  mem_pkg::addr_t    m_addr,
  input  mem_pkg::data_t    m_data,
  input  mem_pkg::mem_tag_t mem_response,
  input  mem_pkg::mem_tag_t mem_tag,
  input  mem_pkg::data_t    mem_data,
  output mem_pkg::mem_tag_t i_response,
  output mem_pkg::mem_tag_t m_response,
  output mem_pkg::mem_tag_t i_mem_tag,
  output mem_pkg::data_t    i_mem_data,
  output mem_pkg::mem_tag_t m_mem_tag,
  output mem_pkg::data_t    m_mem_data,
  output mem_pkg::bus_cmd_e mem_cmd,
  output mem_pkg::addr_t    mem_addr,
  output mem_pkg::data_t    mem_data_out
);
  import mem_pkg::*;

  logic                d_owns;
  logic                load_accepted;
  logic                ret_to_d;
  logic [NUM_TAGS-1:0] tag_owner_d;

  // data side wins whenever it asks
  assign d_owns = (m_cmd != BUS_NONE);

  assign mem_cmd      = d_owns ? m_cmd : i_cmd;
  assign mem_addr     = d_owns ? m_addr : i_addr;
  assign mem_data_out = d_owns ? m_data : '0;

  // loser sees a refusal
  assign m_response = d_owns ? mem_response : '0;
  assign i_response = d_owns ? '0 : mem_response;

  assign load_accepted = (mem_cmd == BUS_LOAD) && (mem_response != '0);

  // one bit per tag, set when the data side owns it
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tag_owner_d <= '0;
    end else begin
      if (mem_tag != '0) begin
        tag_owner_d[mem_tag] <= 1'b0;
      end
      if (load_accepted) begin
        tag_owner_d[mem_response] <= d_owns;
      end
    end
  end

  // steer returning data to whoever asked
  assign ret_to_d   = (mem_tag != '0) && tag_owner_d[mem_tag];
  assign m_mem_tag  = ret_to_d ? mem_tag : '0;
  assign m_mem_data = ret_to_d ? mem_data : '0;
  assign i_mem_tag  = ret_to_d ? '0 : mem_tag;
  assign i_mem_data = ret_to_d ? '0 : mem_data;

endmodule

// File: src/mem_subsystem.sv
`timescale 1ns/1ns

module mem_subsystem (
  input  logic              clock,
  input  logic              rst_n,
  input  mem_pkg::addr_t    fetch_addr,
  input  mem_pkg::bus_cmd_e d_cmd,
  input  mem_pkg::addr_t    d_addr,
  input  mem_pkg::data_t    d_data,
  input  mem_pkg::mem_tag_t mem2proc_response,
  input  mem_pkg::data_t    mem2proc_data,
  input  mem_pkg::mem_tag_t mem2proc_tag,
  output mem_pkg::data_t    fetch_data,
  output logic              fetch_valid,
  output logic              d_ready,
  output logic              d_load_valid,
  output mem_pkg::addr_t    d_load_addr,
  output mem_pkg::data_t    d_load_data,
  output mem_pkg::bus_cmd_e proc2mem_command,
  output mem_pkg::addr_t    proc2mem_addr,
  output mem_pkg::data_t    proc2mem_data
);
  import mem_pkg::*;

  // instruction side
  bus_cmd_e i_cmd;
  addr_t    i_addr;
  mem_tag_t i_response;
  mem_tag_t i_mem_tag;
  data_t    i_mem_data;

  // data side
  bus_cmd_e m_cmd;
  addr_t    m_addr;
  data_t    m_data;
  mem_tag_t m_response;
  mem_tag_t m_mem_tag;
  data_t    m_mem_data;

  icache_ctrl icache_ctrl_i (
    .clock       (clock),
    .rst_n       (rst_n),
    .fetch_addr  (fetch_addr),
    .i_response  (i_response),
    .i_mem_tag   (i_mem_tag),
    .i_mem_data  (i_mem_data),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .i_cmd       (i_cmd),
    .i_addr      (i_addr)
  );

  mshr mshr_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .d_cmd        (d_cmd),
    .d_addr       (d_addr),
    .d_data       (d_data),
    .m_response   (m_response),
    .m_mem_tag    (m_mem_tag),
    .m_mem_data   (m_mem_data),
    .d_ready      (d_ready),
    .d_load_valid (d_load_valid),
    .d_load_addr  (d_load_addr),
    .d_load_data  (d_load_data),
    .m_cmd        (m_cmd),
    .m_addr       (m_addr),
    .m_data       (m_data)
  );

  mem_bus_arbiter mem_bus_arbiter_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .i_cmd        (i_cmd),
    .i_addr       (i_addr),
    .m_cmd        (m_cmd),
    .m_addr       (m_addr),
    .m_data       (m_data),
    .mem_response (mem2proc_response),
    .mem_tag      (mem2proc_tag),
    .mem_data     (mem2proc_data),
    .i_response   (i_response),
    .m_response   (m_response),
    .i_mem_tag    (i_mem_tag),
    .i_mem_data   (i_mem_data),
    .m_mem_tag    (m_mem_tag),
    .m_mem_data   (m_mem_data),
    .mem_cmd      (proc2mem_command),
    .mem_addr     (proc2mem_addr),
    .mem_data_out (proc2mem_data)
  );

endmodule

// File: tests/mem_model.sv
`timescale 1ns/1ns

module mem_model #(
  parameter mem_pkg::data_t FILL_KEY = '0
) (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              hold_off,
  input  mem_pkg::bus_cmd_e proc2mem_command,
  input  mem_pkg::addr_t    proc2mem_addr,
  input  mem_pkg::data_t    proc2mem_data,
  output mem_pkg::mem_tag_t mem2proc_response,
  output mem_pkg::mem_tag_t mem2proc_tag,
  output mem_pkg::data_t    mem2proc_data
);
  import mem_pkg::*;

  localparam int          READ_LAT = 3;
  localparam logic [16:0] SEED     = 17'd85731;

  data_t       words [addr_t];
  logic [16:0] lfsr;
  logic [16:0] lfsr_next;
  logic        refuse;
  mem_tag_t    next_tag;
  addr_t       word_addr;
  mem_tag_t    pipe_tag  [READ_LAT];
  data_t       pipe_data [READ_LAT];

  // x^17 + x^14 + 1, new bit enters at the bottom
  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  // untouched words read back as address xor key
  function automatic data_t read_word(input addr_t a);
    if (words.exists(a)) begin
      return words[a];
    end
    return a ^ FILL_KEY;
  endfunction

  assign lfsr_next = lfsr_step(lfsr);
  assign word_addr = {proc2mem_addr[ADDR_W-1:BLOCK_OFS_W], {BLOCK_OFS_W{1'b0}}};

  // same-cycle answer, zero when idle or refused
  assign mem2proc_response = (rst_n && !hold_off && !refuse &&
                              (proc2mem_command != BUS_NONE)) ? next_tag : '0;
  assign mem2proc_tag  = pipe_tag[READ_LAT-1];
  assign mem2proc_data = pipe_data[READ_LAT-1];

  always @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      lfsr     <= SEED;
      refuse   <= 1'b0;
      next_tag <= 4'd1;
      for (int i = 0; i < READ_LAT; i++) begin
        pipe_tag[i]  <= '0;
        pipe_data[i] <= '0;
      end
    end else begin
      // one lfsr bit per cycle decides refusal
      lfsr   <= lfsr_next;
      refuse <= lfsr_next[0];
      for (int i = 1; i < READ_LAT; i++) begin
        pipe_tag[i]  <= pipe_tag[i-1];
        pipe_data[i] <= pipe_data[i-1];
      end
      pipe_tag[0]  <= '0;
      pipe_data[0] <= '0;
      if (mem2proc_response != '0) begin
        next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        if (proc2mem_command == BUS_LOAD) begin
          pipe_tag[0]  <= mem2proc_response;
          pipe_data[0] <= read_word(word_addr);
        end else begin
          words[word_addr] = proc2mem_data;
        end
      end
    end
  end

endmodule

// File: tests/mem_subsystem_tb.sv
`timescale 1ns/1ns

module mem_subsystem_tb;
  import mem_pkg::*;

  localparam data_t FILL_KEY = 64'h5a5a_c3c3_0f0f_9696;

  typedef enum logic [2:0] {OP_FETCH, OP_LOAD, OP_STORE, OP_HOLD, OP_RELEASE, OP_FULL} op_e;

  typedef struct {
    op_e   op;
    addr_t addr;
    data_t data;
    logic  wait_done;
    logic  expect_hit;
  } row_t;

  logic     clock;
  logic     rst_n;
  logic     hold_off;
  addr_t    fetch_addr;
  bus_cmd_e d_cmd;
  addr_t    d_addr;
  data_t    d_data;
  mem_tag_t mem2proc_response;
  mem_tag_t mem2proc_tag;
  data_t    mem2proc_data;
  data_t    fetch_data;
  logic     fetch_valid;
  logic     d_ready;
  logic     d_load_valid;
  addr_t    d_load_addr;
  data_t    d_load_data;
  bus_cmd_e proc2mem_command;
  addr_t    proc2mem_addr;
  data_t    proc2mem_data;

  row_t     stim [$];
  data_t    ref_mem [addr_t];
  addr_t    exp_addr_q [$];
  data_t    exp_data_q [$];
  // data requests held by the queue and not yet taken by memory
  bus_cmd_e pend_cmd_q [$];
  addr_t    pend_addr_q [$];
  data_t    pend_data_q [$];
  int       errors = 0;
  int       checks = 0;
  int       cycle_count = 0;
  int       cycle_limit = 0;

  mem_subsystem mem_subsystem_i (.*);

  mem_model #(.FILL_KEY(FILL_KEY)) mem_model_i (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic addr_t block_of(input addr_t a);
    return {a[ADDR_W-1:BLOCK_OFS_W], {BLOCK_OFS_W{1'b0}}};
  endfunction

  function automatic data_t ref_word(input addr_t a);
    if (ref_mem.exists(block_of(a))) begin
      return ref_mem[block_of(a)];
    end
    return block_of(a) ^ FILL_KEY;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_cmd(input string name, input bus_cmd_e got, input bus_cmd_e exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic add_row(input op_e op, input addr_t a, input data_t d,
                         input logic wait_done, input logic expect_hit);
    row_t r;
    r.op         = op;
    r.addr       = a;
    r.data       = d;
    r.wait_done  = wait_done;
    r.expect_hit = expect_hit;
    stim.push_back(r);
  endtask

  task automatic build_table();
    // miss, then hits inside the same block
    add_row(OP_FETCH, 64'h0100, '0, 1'b1, 1'b0);
    add_row(OP_FETCH, 64'h0104, '0, 1'b0, 1'b1);
    // index 8 with tags 0x10 and 0x20
    add_row(OP_FETCH, 64'h1040, '0, 1'b1, 1'b0);
    add_row(OP_FETCH, 64'h2040, '0, 1'b1, 1'b0);
    add_row(OP_FETCH, 64'h1040, '0, 1'b1, 1'b0);
    add_row(OP_FETCH, 64'h2044, '0, 1'b1, 1'b0);
    add_row(OP_STORE, 64'h8000, 64'h1111_2222_3333_4444, 1'b0, 1'b0);
    add_row(OP_STORE, 64'h8008, 64'hdead_beef_0bad_f00d, 1'b0, 1'b0);
    add_row(OP_LOAD,  64'h8000, '0, 1'b0, 1'b0);
    add_row(OP_LOAD,  64'h8010, '0, 1'b0, 1'b0);
    add_row(OP_STORE, 64'h8000, 64'h7654_3210_fedc_ba98, 1'b0, 1'b0);
    add_row(OP_LOAD,  64'h8000, '0, 1'b0, 1'b0);
    add_row(OP_LOAD,  64'h8008, '0, 1'b1, 1'b0);
    // fetch misses left open while data requests go out
    add_row(OP_FETCH, 64'h3000, '0, 1'b0, 1'b0);
    add_row(OP_LOAD,  64'h8000, '0, 1'b0, 1'b0);
    add_row(OP_STORE, 64'h8018, 64'h0123_4567_89ab_cdef, 1'b0, 1'b0);
    add_row(OP_LOAD,  64'h8018, '0, 1'b0, 1'b0);
    add_row(OP_FETCH, 64'h3000, '0, 1'b1, 1'b0);
    add_row(OP_FETCH, 64'h4100, '0, 1'b0, 1'b0);
    add_row(OP_LOAD,  64'h9000, '0, 1'b0, 1'b0);
    add_row(OP_FETCH, 64'h4100, '0, 1'b1, 1'b0);
    add_row(OP_LOAD,  64'h9008, '0, 1'b1, 1'b0);
    // fill the queue while memory refuses everything
    add_row(OP_HOLD,  '0, '0, 1'b0, 1'b0);
    add_row(OP_LOAD,  64'ha000, '0, 1'b0, 1'b0);
    add_row(OP_STORE, 64'ha008, 64'h5555_aaaa_5555_aaaa, 1'b0, 1'b0);
    add_row(OP_LOAD,  64'ha008, '0, 1'b0, 1'b0);
    add_row(OP_LOAD,  64'ha010, '0, 1'b0, 1'b0);
    add_row(OP_FULL,  '0, '0, 1'b0, 1'b0);
    add_row(OP_RELEASE, '0, '0, 1'b0, 1'b0);
    add_row(OP_LOAD,  64'ha000, '0, 1'b1, 1'b0);
  endtask

  task automatic apply_fetch(input row_t r);
    @(posedge clock);
    #1;
    fetch_addr = r.addr;
    if (r.expect_hit || r.wait_done) begin
      @(negedge clock);
      if (r.expect_hit) begin
        check_bit("fetch_valid", fetch_valid, 1'b1);
      end
      while (!fetch_valid) begin
        @(negedge clock);
      end
      check_data("fetch_data", fetch_data, ref_word(r.addr));
    end
  endtask

  task automatic issue_data(input row_t r);
    @(posedge clock);
    #1;
    while (!d_ready) begin
      @(posedge clock);
      #1;
    end
    d_cmd  = (r.op == OP_LOAD) ? BUS_LOAD : BUS_STORE;
    d_addr = r.addr;
    d_data = r.data;
    if (r.op == OP_LOAD) begin
      exp_addr_q.push_back(r.addr);
      exp_data_q.push_back(ref_word(r.addr));
    end else begin
      ref_mem[block_of(r.addr)] = r.data;
    end
    @(posedge clock);
    #1;
    pend_cmd_q.push_back(d_cmd);
    pend_addr_q.push_back(r.addr);
    pend_data_q.push_back(r.data);
    d_cmd = BUS_NONE;
    while (r.wait_done && (exp_addr_q.size() != 0)) begin
      @(posedge clock);
    end
  endtask

  always @(negedge clock) begin
    if (rst_n && d_load_valid) begin
      if (exp_addr_q.size() == 0) begin
        $display("load result for 0x%h arrived with no load outstanding", d_load_addr);
        errors++;
      end else begin
        check_addr("d_load_addr", d_load_addr, exp_addr_q.pop_front());
        check_data("d_load_data", d_load_data, exp_data_q.pop_front());
      end
    end
    // oldest unissued data request owns the bus
    if (rst_n && (pend_cmd_q.size() != 0)) begin
      check_cmd("proc2mem_command", proc2mem_command, pend_cmd_q[0]);
      check_addr("proc2mem_addr", proc2mem_addr, pend_addr_q[0]);
      if (pend_cmd_q[0] == BUS_STORE) begin
        check_data("proc2mem_data", proc2mem_data, pend_data_q[0]);
      end
      if (mem2proc_response != '0) begin
        void'(pend_cmd_q.pop_front());
        void'(pend_addr_q.pop_front());
        void'(pend_data_q.pop_front());
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if ((cycle_limit != 0) && (cycle_count >= cycle_limit)) begin
      $display("timeout after %0d cycles, errors %0d, checks %0d", cycle_count, errors, checks);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    rst_n      = 1'b0;
    hold_off   = 1'b0;
    fetch_addr = '0;
    d_cmd      = BUS_NONE;
    d_addr     = '0;
    d_data     = '0;
    build_table();
    cycle_limit = stim.size() * 40;
    @(posedge clock);
    @(negedge clock);
    // bus idle and queue empty while reset is held
    check_cmd("proc2mem_command", proc2mem_command, BUS_NONE);
    check_bit("fetch_valid", fetch_valid, 1'b0);
    check_bit("d_load_valid", d_load_valid, 1'b0);
    check_bit("d_ready", d_ready, 1'b1);
    @(posedge clock);
    #1;
    rst_n = 1'b1;
    foreach (stim[i]) begin
      case (stim[i].op)
        OP_FETCH: apply_fetch(stim[i]);
        OP_HOLD, OP_RELEASE: begin
          @(posedge clock);
          #1;
          hold_off = (stim[i].op == OP_HOLD);
        end
        OP_FULL: begin
          @(posedge clock);
          #1;
          check_bit("d_ready", d_ready, 1'b0);
        end
        default: issue_data(stim[i]);
      endcase
    end
    if ((exp_addr_q.size() != 0) || (pend_cmd_q.size() != 0)) begin
      $display("data requests were still outstanding when the table ended");
      errors++;
    end
    $display("errors %0d, checks %0d, cycles %0d", errors, checks, cycle_count);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: mem_subsystem.f
common/mem_pkg.sv
icache/icache_mem.sv
icache/icache_ctrl.sv
mshr/mshr.sv
src/mem_bus_arbiter.sv
src/mem_subsystem.sv
tests/mem_model.sv
tests/mem_subsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FLIST     ?= mem_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
